// File: flist.f
+incdir+include
hdl/bj_pkg.sv
hdl/hand_store.sv
hdl/coin_bank.sv
hdl/bj_fsm.sv
hdl/bj_top.sv
dv/bj_tb.sv

// File: Bender.yml
package:
  name: bj_round

sources:
  - include_dirs:
      - include
    files:
      - hdl/bj_pkg.sv
      - hdl/hand_store.sv
      - hdl/coin_bank.sv
      - hdl/bj_fsm.sv
      - hdl/bj_top.sv
      - target: test
        files:
          - dv/bj_tb.sv

// File: dv/bj_tb.sv
`timescale 1ns/10ps
`include "bj_config.svh"

module bj_tb
    import bj_pkg::*;
();

    localparam int TABLE_ROWS      = 13;
    localparam int RAND_ROWS       = 6;
    localparam int NUM_ROWS        = TABLE_ROWS + RAND_ROWS;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 200 + 20;   // reset plus slack

    logic   clk = 1'b0;
    logic   reset;
    bet_t   bet;
    logic   next;
    logic   hit;
    logic   stand;
    card_t  card_in = card_t'(1);
    logic   card_take;
    logic   bet_open;
    score_t player_score;
    score_t dealer_score;
    coin_t  coins;
    logic   win;
    logic   lose;
    logic   draw;

    int          errors = 0;
    int          seed = 32'hb67;
    int          take_count = 0;   // card_take strobes since time zero
    int          deck_base = 0;    // take_count when the current deck was loaded
    logic [39:0] deck_cur = '0;    // ten cards, first card in the top nibble

    // stimulus table
    string       row_name [NUM_ROWS];
    int          row_bet [NUM_ROWS];
    logic [39:0] row_deck [NUM_ROWS];
    int          row_hits [NUM_ROWS];
    outcome_e    row_out [NUM_ROWS];
    int          row_coins [NUM_ROWS];
    bit          row_random [NUM_ROWS];
    int          n_rows = 0;

    bj_top dut (
        .clk          (clk),
        .reset        (reset),
        .bet          (bet),
        .next         (next),
        .hit          (hit),
        .stand        (stand),
        .card_in      (card_in),
        .card_take    (card_take),
        .bet_open     (bet_open),
        .player_score (player_score),
        .dealer_score (dealer_score),
        .coins        (coins),
        .win          (win),
        .lose         (lose),
        .draw         (draw)
    );

    always #2 clk = ~clk;   // 4 ns period

    // --------------------------------------------------
    // card feeder
    // --------------------------------------------------
    always @(posedge clk) begin
        if (card_take) begin
            take_count <= take_count + 1;
        end
    end

    always @(posedge clk) begin
        #1;
        card_in = card_at(deck_cur, take_count - deck_base);   // next card before the next edge
    end

    function automatic card_t card_at(input logic [39:0] deck, input int idx);
        if (idx < 0 || idx > 9) begin
            return card_t'(2);   // past the deck
        end
        return deck[39 - 4 * idx -: 4];
    endfunction

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic int hand_value(input int sum, input bit ace);
        if (ace && sum + `BJ_ACE_BONUS <= `BJ_TARGET) begin
            return sum + `BJ_ACE_BONUS;
        end
        return sum;
    endfunction

    task automatic draw_card(input card_t c, inout int sum, inout bit ace, inout int n);
        sum = sum + int'(c);
        n   = n + 1;
        if (c == card_t'(1)) begin
            ace = 1'b1;
        end
    endtask

    task automatic play_model(input logic [39:0] deck, input int hits, input int stake,
                              input int bank_in, output outcome_e outc, output int bank_out,
                              output int p_val, output int d_val, output int takes);
        int p_sum = 0;
        int p_n = 0;
        int d_sum = 0;
        int d_n = 0;
        int idx = 0;
        int h = 0;
        int pay = 0;
        bit p_ace = 1'b0;
        bit d_ace = 1'b0;
        outc     = OUT_NONE;
        bank_out = bank_in;
        p_val    = 0;
        d_val    = 0;
        takes    = 0;
        if (stake == 0 || stake > bank_in) begin
            return;   // bet refused, nothing dealt
        end
        // player, dealer, player, dealer
        for (idx = 0; idx < 4; idx++) begin
            if (idx % 2 == 0) begin
                draw_card(card_at(deck, idx), p_sum, p_ace, p_n);
            end else begin
                draw_card(card_at(deck, idx), d_sum, d_ace, d_n);
            end
        end
        while (h < hits && hand_value(p_sum, p_ace) < `BJ_TARGET && p_n < `BJ_MAX_CARDS) begin
            draw_card(card_at(deck, idx), p_sum, p_ace, p_n);
            idx++;
            h++;
        end
        p_val = hand_value(p_sum, p_ace);
        if (p_val <= `BJ_TARGET) begin   // dealer plays only against a live hand
            while (hand_value(d_sum, d_ace) < `BJ_DEALER_STAND && d_n < `BJ_MAX_CARDS) begin
                draw_card(card_at(deck, idx), d_sum, d_ace, d_n);
                idx++;
            end
        end
        d_val = hand_value(d_sum, d_ace);
        if (p_val > `BJ_TARGET) begin
            outc = OUT_LOSE;
        end else if (d_val > `BJ_TARGET || p_val > d_val) begin
            outc = (p_n == 2 && p_val == `BJ_TARGET) ? OUT_BLACKJACK : OUT_WIN;
        end else if (p_val == d_val) begin
            outc = OUT_DRAW;
        end else begin
            outc = OUT_LOSE;
        end
        case (outc)
            OUT_BLACKJACK: pay = 3 * stake;
            OUT_WIN:       pay = 2 * stake;
            OUT_DRAW:      pay = stake;
            default:       pay = 0;
        endcase
        bank_out = bank_in - stake + pay;
        if (bank_out > `BJ_COIN_MAX) begin
            bank_out = `BJ_COIN_MAX;
        end
        takes = idx;
    endtask

    function automatic logic [2:0] result_flags(input outcome_e o);
        case (o)
            OUT_WIN, OUT_BLACKJACK: return 3'b100;   // {win, lose, draw}
            OUT_LOSE:               return 3'b010;
            OUT_DRAW:               return 3'b001;
            default:                return 3'b000;
        endcase
    endfunction

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", what, expected, actual);
            errors++;
        end
    endtask

    task automatic advance_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic add_row(input string name, input int stake, input logic [39:0] deck,
                           input int hits, input outcome_e out, input int coins_after);
        row_name[n_rows]   = name;
        row_bet[n_rows]    = stake;
        row_deck[n_rows]   = deck;
        row_hits[n_rows]   = hits;
        row_out[n_rows]    = out;
        row_coins[n_rows]  = coins_after;
        row_random[n_rows] = 1'b0;
        n_rows++;
    endtask

    task automatic load_table();
        logic [39:0] deck;
        int          i;
        int          k;
        int          stake;
        int          hits;
        //       name             bet  deck (P D P D, then draws)  hits  outcome        coins
        add_row("refuse_zero",    0,  40'hA_A_9_8_2_2_2_2_2_2,   0,    OUT_NONE,      30);
        add_row("stand_win",      5,  40'hA_A_9_8_2_2_2_2_2_2,   0,    OUT_WIN,       35);
        add_row("stand_lose",     10, 40'hA_A_7_9_2_2_2_2_2_2,   0,    OUT_LOSE,      25);
        add_row("stand_draw",     4,  40'hA_A_8_8_2_2_2_2_2_2,   0,    OUT_DRAW,      25);
        add_row("soft_ace_hit",   3,  40'h1_A_6_6_A_A_2_2_2_2,   1,    OUT_WIN,       28);
        add_row("player_bust",    8,  40'hA_A_6_5_A_2_2_2_2_2,   2,    OUT_LOSE,      20);
        add_row("dealer_full",    6,  40'hA_2_9_3_4_5_2_2_2_2,   0,    OUT_WIN,       26);
        add_row("dealer_bust",    7,  40'hA_A_8_4_9_2_2_2_2_2,   0,    OUT_WIN,       33);
        add_row("dealer_soft17",  15, 40'hA_1_6_6_2_2_2_2_2_2,   0,    OUT_LOSE,      18);
        add_row("blackjack",      4,  40'h1_A_A_7_2_2_2_2_2_2,   0,    OUT_BLACKJACK, 26);
        add_row("big_loss",       15, 40'hA_A_2_8_2_2_2_2_2_2,   0,    OUT_LOSE,      11);
        add_row("refuse_over",    12, 40'hA_A_9_8_2_2_2_2_2_2,   0,    OUT_NONE,      11);
        add_row("hit_to_21",      11, 40'h5_A_6_6_A_2_2_2_2_2,   2,    OUT_WIN,       22);
        // random rows, expected values come from the model at run time
        for (i = 0; i < RAND_ROWS; i++) begin
            for (k = 0; k < 10; k++) begin
                deck[39 - 4 * k -: 4] = 4'(({$random(seed)} % 10) + 1);
            end
            stake = ({$random(seed)} % 15) + 1;
            hits  = {$random(seed)} % 4;
            add_row($sformatf("random_%0d", i), stake, deck, hits, OUT_NONE, 0);
            row_random[n_rows - 1] = 1'b1;
        end
    endtask

    // --------------------------------------------------
    // one round through the DUT
    // --------------------------------------------------
    task automatic run_round(input string name, input int stake, input logic [39:0] deck,
                             input int hits, input outcome_e exp_out, input int exp_coins,
                             input int exp_p, input int exp_d, input int exp_takes);
        int start;
        int i;
        start     = take_count;
        deck_base = take_count;
        deck_cur  = deck;
        bet       = bet_t'(stake);
        advance_cycle();   // feeder shows the first card
        next = 1'b1;
        advance_cycle();
        next = 1'b0;
        if (exp_out == OUT_NONE) begin
            repeat (4) advance_cycle();
            check_value({name, " takes"}, 0, take_count - start);
            check_value({name, " bet_open"}, 1, bet_open);
            check_value({name, " coins"}, exp_coins, coins);
            return;
        end
        while (take_count - start < 4) begin   // deal
            advance_cycle();
        end
        check_value({name, " bet_open in play"}, 0, bet_open);
        for (i = 0; i < hits; i++) begin
            hit = 1'b1;
            advance_cycle();
            hit = 1'b0;
            advance_cycle();   // new score settles
        end
        stand = 1'b1;
        advance_cycle();
        stand = 1'b0;
        while (!(win || lose || draw)) begin
            advance_cycle();
        end
        check_value({name, " result"}, result_flags(exp_out), {win, lose, draw});
        check_value({name, " player_score"}, exp_p, player_score);
        check_value({name, " dealer_score"}, exp_d, dealer_score);
        advance_cycle();   // settle lands here
        check_value({name, " coins"}, exp_coins, coins);
        check_value({name, " takes"}, exp_takes, take_count - start);
        next = 1'b1;
        advance_cycle();
        next = 1'b0;
        check_value({name, " bet_open"}, 1, bet_open);
        check_value({name, " cleared"}, 0, {win, lose, draw});
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int       r;
        int       bank;
        int       stake;
        int       p_val;
        int       d_val;
        int       takes;
        int       exp_coins;
        int       model_coins;
        outcome_e exp_out;
        outcome_e model_out;
        reset = 1'b1;
        bet   = '0;
        next  = 1'b0;
        hit   = 1'b0;
        stand = 1'b0;
        load_table();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        advance_cycle();
        check_value("reset coins", `BJ_START_COINS, coins);
        check_value("reset bet_open", 1, bet_open);
        check_value("reset strobes", 0, {win, lose, draw, card_take});
        bank = `BJ_START_COINS;
        for (r = 0; r < n_rows; r++) begin
            stake = row_bet[r];
            if (row_random[r] && stake > bank) begin
                stake = bank;
            end
            play_model(row_deck[r], row_hits[r], stake, bank, model_out, model_coins,
                       p_val, d_val, takes);
            exp_out   = row_random[r] ? model_out : row_out[r];
            exp_coins = row_random[r] ? model_coins : row_coins[r];
            run_round(row_name[r], stake, row_deck[r], row_hits[r], exp_out, exp_coins,
                      p_val, d_val, takes);
            bank = exp_coins;
        end
        $display("%0d errors over %0d rounds", errors, n_rows);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles with %0d errors, a round never ended",
                 WATCHDOG_CYCLES, errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: hdl/bj_top.sv
`timescale 1ns/10ps

module bj_top
    import bj_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  bet_t   bet,
    input  logic   next,
    input  logic   hit,
    input  logic   stand,
    input  card_t  card_in,
    output logic   card_take,
    output logic   bet_open,
    output score_t player_score,
    output score_t dealer_score,
    output coin_t  coins,
    output logic   win,
    output logic   lose,
    output logic   draw
);

    hand_op_e player_op;
    hand_op_e dealer_op;
    logic     player_full;
    logic     dealer_full;
    logic     player_natural;
    logic     bet_ok;
    logic     take_bet;
    logic     settle;
    outcome_e outcome;

    // --------------------------------------------------
    // round control
    // --------------------------------------------------
    bj_fsm u_fsm (
        .clk            (clk),
        .reset          (reset),
        .next           (next),
        .hit            (hit),
        .stand          (stand),
        .bet_ok         (bet_ok),
        .player_score   (player_score),
        .dealer_score   (dealer_score),
        .player_full    (player_full),
        .dealer_full    (dealer_full),
        .player_natural (player_natural),
        .player_op      (player_op),
        .dealer_op      (dealer_op),
        .card_take      (card_take),
        .take_bet       (take_bet),
        .settle         (settle),
        .outcome        (outcome),
        .bet_open       (bet_open),
        .win            (win),
        .lose           (lose),
        .draw           (draw)
    );

    // both hands see every card, the op picks who loads it
    hand_store u_player (
        .clk     (clk),
        .reset   (reset),
        .op      (player_op),
        .card    (card_in),
        .score   (player_score),
        .full    (player_full),
        .natural (player_natural)
    );

    hand_store u_dealer (
        .clk     (clk),
        .reset   (reset),
        .op      (dealer_op),
        .card    (card_in),
        .score   (dealer_score),
        .full    (dealer_full),
        .natural ()              // dealer natural is covered by the score compare
    );

    // --------------------------------------------------
    // coins
    // --------------------------------------------------
    coin_bank u_bank (
        .clk      (clk),
        .reset    (reset),
        .bet      (bet),
        .take_bet (take_bet),
        .settle   (settle),
        .outcome  (outcome),
        .coins    (coins),
        .bet_ok   (bet_ok)
    );

endmodule

// File: hdl/bj_fsm.sv
`timescale 1ns/10ps
`include "bj_config.svh"

module bj_fsm
    import bj_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     next,
    input  logic     hit,
    input  logic     stand,
    input  logic     bet_ok,
    input  score_t   player_score,
    input  score_t   dealer_score,
    input  logic     player_full,
    input  logic     dealer_full,
    input  logic     player_natural,
    output hand_op_e player_op,
    output hand_op_e dealer_op,
    output logic     card_take,
    output logic     take_bet,
    output logic     settle,
    output outcome_e outcome,
    output logic     bet_open,
    output logic     win,
    output logic     lose,
    output logic     draw
);

    bj_phase_e  phase;
    bj_phase_e  phase_nxt;
    logic [1:0] deal_step;      // card number within the deal
    outcome_e   judged;         // live verdict, latched on entry to result
    logic       player_bust;
    logic       enter_result;

    assign player_bust  = (player_score > score_t'(`BJ_TARGET));
    assign enter_result = (phase != PH_RESULT) && (phase_nxt == PH_RESULT);

    // --------------------------------------------------
    // outcome judge
    // --------------------------------------------------
    always_comb begin
        if (player_bust) begin
            judged = OUT_LOSE;
        end else if (dealer_score > score_t'(`BJ_TARGET)) begin
            judged = OUT_WIN;
        end else if (player_score > dealer_score) begin
            judged = OUT_WIN;
        end else if (player_score == dealer_score) begin
            judged = OUT_DRAW;
        end else begin
            judged = OUT_LOSE;
        end
        // a tie at 21 stays a draw, so this only upgrades a win
        if (judged == OUT_WIN && player_natural) begin
            judged = OUT_BLACKJACK;
        end
    end

    // --------------------------------------------------
    // next phase and strobes
    // --------------------------------------------------
    always_comb begin
        phase_nxt = phase;
        player_op = HAND_HOLD;
        dealer_op = HAND_HOLD;
        card_take = 1'b0;
        take_bet  = 1'b0;
        case (phase)
            PH_BET: begin
                if (next && bet_ok) begin
                    take_bet  = 1'b1;
                    phase_nxt = PH_DEAL;
                end
            end
            PH_DEAL: begin
                card_take = 1'b1;
                // even steps to the player, odd to the dealer
                if (deal_step[0]) begin
                    dealer_op = HAND_ADD;
                end else begin
                    player_op = HAND_ADD;
                end
                if (deal_step == 2'd3) begin
                    phase_nxt = PH_PLAYER;
                end
            end
            PH_PLAYER: begin
                if (player_bust) begin
                    phase_nxt = PH_RESULT;   // dealer never draws
                end else if (stand || player_score == score_t'(`BJ_TARGET)) begin
                    phase_nxt = PH_DEALER;
                end else if (hit && !player_full) begin
                    card_take = 1'b1;
                    player_op = HAND_ADD;
                end
            end
            PH_DEALER: begin
                // score of the card just taken shows up next cycle
                if (dealer_score < score_t'(`BJ_DEALER_STAND) && !dealer_full) begin
                    card_take = 1'b1;
                    dealer_op = HAND_ADD;
                end else begin
                    phase_nxt = PH_RESULT;
                end
            end
            PH_RESULT: begin
                if (next) begin
                    player_op = HAND_CLEAR;
                    dealer_op = HAND_CLEAR;
                    phase_nxt = PH_BET;
                end
            end
            default: begin
                phase_nxt = PH_BET;
            end
        endcase
    end

    // --------------------------------------------------
    // state registers
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase     <= PH_BET;
            deal_step <= '0;
            outcome   <= OUT_NONE;
            settle    <= 1'b0;
        end else begin
            phase  <= phase_nxt;
            settle <= enter_result;                  // first result cycle only
            if (phase == PH_DEAL) begin
                deal_step <= deal_step + 2'd1;       // wraps back to 0 after 4
            end
            if (enter_result) begin
                outcome <= judged;
            end else if (phase_nxt == PH_BET) begin
                outcome <= OUT_NONE;
            end
        end
    end

    // status decode
    assign bet_open = (phase == PH_BET);
    assign win      = (outcome == OUT_WIN) || (outcome == OUT_BLACKJACK);
    assign lose     = (outcome == OUT_LOSE);
    assign draw     = (outcome == OUT_DRAW);

endmodule

// File: hdl/coin_bank.sv
`timescale 1ns/10ps
`include "bj_config.svh"

module coin_bank
    import bj_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  bet_t     bet,
    input  logic     take_bet,
    input  logic     settle,
    input  outcome_e outcome,
    output coin_t    coins,
    output logic     bet_ok
);

    bet_t       bet_q;    // stake of the running round
    logic [8:0] payout;   // 3 x 15 at most
    logic [8:0] credit;   // balance plus payout, before the clamp

    // nonzero and covered by the balance
    assign bet_ok = (bet != '0) && (coin_t'(bet) <= coins);

    // --------------------------------------------------
    // payout select
    // --------------------------------------------------
    always_comb begin
        case (outcome)
            OUT_BLACKJACK: payout = 9'(bet_q) * 9'd3;
            OUT_WIN:       payout = 9'(bet_q) << 1;
            OUT_DRAW:      payout = 9'(bet_q);
            default:       payout = '0;   // loss pays nothing
        endcase
    end

    assign credit = {1'b0, coins} + payout;

    // --------------------------------------------------
    // balance
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coins <= coin_t'(`BJ_START_COINS);
        end else if (take_bet) begin
            coins <= coins - coin_t'(bet);   // bet_ok keeps this from wrapping
        end else if (settle) begin
            if (credit > 9'(`BJ_COIN_MAX)) begin
                coins <= coin_t'(`BJ_COIN_MAX);
            end else begin
                coins <= credit[7:0];
            end
        end
    end

    // stake is latched once per round
    always_ff @(posedge clk) begin
        if (take_bet) begin
            bet_q <= bet;
        end
    end

endmodule

// File: hdl/hand_store.sv
`timescale 1ns/10ps
`include "bj_config.svh"

module hand_store
    import bj_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  hand_op_e op,
    input  card_t    card,
    output score_t   score,
    output logic     full,
    output logic     natural
);

    logic [2:0] count;      // cards held
    score_t     hard_sum;   // every ace counted as 1
    logic       ace_seen;
    logic [6:0] soft_sum;   // spare bit so the bonus can't wrap

    // --------------------------------------------------
    // hand registers
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count    <= '0;
            hard_sum <= '0;
            ace_seen <= 1'b0;
        end else if (op == HAND_CLEAR) begin
            count    <= '0;
            hard_sum <= '0;
            ace_seen <= 1'b0;
        end else if (op == HAND_ADD && !full) begin
            count    <= count + 3'd1;
            hard_sum <= hard_sum + score_t'(card);
            // value 1 is an ace
            if (card == card_t'(1)) begin
                ace_seen <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // scoring
    // --------------------------------------------------
    assign soft_sum = {1'b0, hard_sum} + 7'(`BJ_ACE_BONUS);

    // at most one ace is promoted, more would always bust
    always_comb begin
        if (ace_seen && soft_sum <= 7'(`BJ_TARGET)) begin
            score = soft_sum[5:0];
        end else begin
            score = hard_sum;
        end
    end

    assign full    = (count == 3'(`BJ_MAX_CARDS));
    assign natural = (count == 3'd2) && (score == score_t'(`BJ_TARGET)); // two-card 21

endmodule

// File: hdl/bj_pkg.sv
package bj_pkg;

    // --------------------------------------------------
    // data widths
    // --------------------------------------------------
    typedef logic [3:0] card_t;   // 1 to 10, ace is 1
    typedef logic [5:0] score_t;  // hand total
    typedef logic [7:0] coin_t;   // balance
    typedef logic [3:0] bet_t;    // 1 to 15 coins

    // round phases
    typedef enum logic [2:0] {
        PH_BET,
        PH_DEAL,
        PH_PLAYER,
        PH_DEALER,
        PH_RESULT
    } bj_phase_e;

    // what a hand store does at the next edge
    typedef enum logic [1:0] {
        HAND_HOLD,
        HAND_ADD,
        HAND_CLEAR
    } hand_op_e;

    // round result, also selects the payout
    typedef enum logic [2:0] {
        OUT_NONE,
        OUT_LOSE,
        OUT_DRAW,
        OUT_WIN,
        OUT_BLACKJACK
    } outcome_e;

endpackage

// File: include/bj_config.svh
`ifndef BJ_CONFIG_SVH
`define BJ_CONFIG_SVH

// --------------------------------------------------
// game rules
// --------------------------------------------------
`define BJ_TARGET        21   // bust limit
`define BJ_DEALER_STAND  17   // dealer stops drawing here
`define BJ_ACE_BONUS     10   // ace as 11 instead of 1

// hand size
`define BJ_MAX_CARDS     5

// --------------------------------------------------
// coin bank
// --------------------------------------------------
`define BJ_START_COINS   30   // balance out of reset
`define BJ_COIN_MAX      255  // balance clamps here

`endif
